/* spart.f */
design/spart_pkg.sv
design/uart_frame_pkg.sv
design/spart_baud_gen.sv
design/spart_rx.sv
design/spart_tx.sv
design/spart_bus_if.sv
design/spart.sv
bench/spart_chk.sv
bench/spart_tb.sv

/* Makefile */
TOOL     := verilator
TOP      := spart_tb
FILELIST := spart.f
FLAGS    := --binary --timing --assert -j 0
LINT     := --lint-only -Wall --timing --assert
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation finished: PASS
FAIL_MSG := Simulation finished: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run ended without a result"; exit 1; }

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/spart_tb.sv */
`timescale 1ns/1ps

module spart_tb;

    localparam logic [15:0] reset_div = 16'd2; // short frames
    localparam int clk_period = 40;

    typedef enum {k_status, k_div_read, k_divisor, k_loopback, k_back2back, k_framing} kind_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    logic                 wr;
    spart_pkg::reg_addr_t addr;
    logic [7:0]           wdata;
    logic                 ack;
    logic [7:0]           rdata;
    logic                 rxd;
    logic                 txd;
    logic                 loop_en;  // txd back to rxd
    logic                 inj_line; // rxd when not looped

    // stimulus table, one entry per test
    string       test_name[$];
    kind_t       test_kind[$];
    logic [15:0] test_value[$];
    logic [15:0] test_expect[$];

    logic [7:0] lfsr;
    int         cycle_count = 0;
    int         last_ack_cycle;
    int         cur_div;
    int         error_count = 0;
    int         failed_tests = 0;
    bit         table_built = 1'b0;

    assign rxd = loop_en ? txd : inj_line;

    spart #(.reset_divisor(reset_div)) dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .rxd   (rxd),
        .txd   (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // galois form, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [7:0] status_byte(input logic tbr, input logic rda, input logic ferr);
        logic [7:0] s;
        s = '0;
        s[spart_pkg::stat_tbr]  = tbr;
        s[spart_pkg::stat_rda]  = rda;
        s[spart_pkg::stat_ferr] = ferr;
        return s;
    endfunction

    task automatic add_test(input string name, input kind_t kind, input logic [15:0] value,
                            input logic [15:0] expected);
        test_name.push_back(name);
        test_kind.push_back(kind);
        test_value.push_back(value);
        test_expect.push_back(expected);
    endtask

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %02h, actual %02h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_status(input string name, input logic [7:0] expected,
                                  input logic [7:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected status %08b, actual %08b", name, expected, actual);
            error_count++;
        end
    endtask

    // one four-phase transfer, entered and left on a rising edge
    task automatic bus_access(input logic write, input spart_pkg::reg_addr_t a,
                              input logic [7:0] d, output logic [7:0] q);
        req   <= 1'b1;
        wr    <= write;
        addr  <= a;
        wdata <= d;
        do @(posedge clk); while (!ack);
        q = rdata; // valid while ack is high
        last_ack_cycle = cycle_count;
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic bus_write(input spart_pkg::reg_addr_t a, input logic [7:0] d);
        logic [7:0] unused;
        bus_access(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input spart_pkg::reg_addr_t a, output logic [7:0] q);
        bus_access(1'b0, a, 8'h00, q);
    endtask

    task automatic wait_rda();
        logic [7:0] s;
        do bus_read(spart_pkg::reg_status, s); while (!s[spart_pkg::stat_rda]);
    endtask

    // start, data lsb first, then a stop bit that is low past its centre
    task automatic send_bad_frame(input logic [7:0] b);
        int bit_cycles;
        bit_cycles = uart_frame_pkg::oversample * (cur_div + 1);
        loop_en  <= 1'b0;
        inj_line <= uart_frame_pkg::line_start;
        repeat (bit_cycles) @(posedge clk);
        for (int i = 0; i < uart_frame_pkg::data_bits; i++) begin
            inj_line <= b[i];
            repeat (bit_cycles) @(posedge clk);
        end
        inj_line <= uart_frame_pkg::line_start;
        repeat (12 * (cur_div + 1)) @(posedge clk); // short, so no false start follows
        inj_line <= uart_frame_pkg::line_idle;
        repeat (3 * bit_cycles) @(posedge clk);
        loop_en <= 1'b1;
    endtask

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        add_test("reset_status", k_status, 16'h0000, {8'h00, status_byte(1'b1, 1'b0, 1'b0)});
        add_test("reset_divisor", k_div_read, 16'h0000, reset_div);
        for (int i = 0; i < 3; i++) begin
            take_random_byte(a);
            add_test($sformatf("loop_rand%0d", i), k_loopback, {8'h00, a}, {8'h00, a});
        end
        add_test("loop_00", k_loopback, 16'h0000, 16'h0000);
        add_test("loop_ff", k_loopback, 16'h00ff, 16'h00ff);
        take_random_byte(a);
        take_random_byte(b);
        add_test("back_to_back", k_back2back, {b, a}, {8'h00, b});
        add_test("framing_error", k_framing, 16'h005a, {8'h00, status_byte(1'b1, 1'b0, 1'b1)});
        add_test("divisor_0107", k_divisor, 16'h0107, 16'h0107);
        add_test("divisor_0005", k_divisor, 16'h0005, 16'h0005);
        for (int i = 0; i < 2; i++) begin
            take_random_byte(a);
            add_test($sformatf("new_div_rand%0d", i), k_loopback, {8'h00, a}, {8'h00, a});
        end
        add_test("final_status", k_status, 16'h0000, {8'h00, status_byte(1'b1, 1'b0, 1'b0)});
    endtask

    initial begin
        logic [7:0] got;
        int         errors_before;
        int         first_ack;
        rst_n    <= 1'b0;
        req      <= 1'b0;
        wr       <= 1'b0;
        addr     <= spart_pkg::reg_data;
        wdata    <= 8'h00;
        loop_en  <= 1'b1;
        inj_line <= uart_frame_pkg::line_idle;
        lfsr     = 8'd94;
        cur_div  = int'(reset_div);
        build_table();
        table_built = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < test_name.size(); i++) begin
            errors_before = error_count;
            case (test_kind[i])
                k_status: begin
                    repeat (uart_frame_pkg::oversample * (cur_div + 1)) @(posedge clk);
                    bus_read(spart_pkg::reg_status, got);
                    compare_status(test_name[i], test_expect[i][7:0], got);
                end
                k_div_read: begin
                    bus_read(spart_pkg::reg_div_lo, got);
                    compare_byte({test_name[i], " lo"}, test_expect[i][7:0], got);
                    bus_read(spart_pkg::reg_div_hi, got);
                    compare_byte({test_name[i], " hi"}, test_expect[i][15:8], got);
                end
                k_divisor: begin
                    bus_write(spart_pkg::reg_div_lo, test_value[i][7:0]);
                    bus_write(spart_pkg::reg_div_hi, test_value[i][15:8]);
                    cur_div = int'(test_value[i]);
                    bus_read(spart_pkg::reg_div_lo, got);
                    compare_byte({test_name[i], " lo"}, test_expect[i][7:0], got);
                    bus_read(spart_pkg::reg_div_hi, got);
                    compare_byte({test_name[i], " hi"}, test_expect[i][15:8], got);
                end
                k_loopback: begin
                    bus_write(spart_pkg::reg_data, test_value[i][7:0]);
                    wait_rda();
                    bus_read(spart_pkg::reg_data, got);
                    compare_byte(test_name[i], test_expect[i][7:0], got);
                end
                k_back2back: begin
                    bus_write(spart_pkg::reg_data, test_value[i][7:0]);
                    first_ack = last_ack_cycle;
                    bus_write(spart_pkg::reg_data, test_value[i][15:8]); // stalls on tbr
                    if (last_ack_cycle - first_ack < 9 * 16 * (cur_div + 1)) begin
                        $display("%s: second write accepted after %0d cycles, transmitter busy",
                                 test_name[i], last_ack_cycle - first_ack);
                        error_count++;
                    end
                    bus_read(spart_pkg::reg_data, got); // first byte, before the next start
                    compare_byte({test_name[i], " first"}, test_value[i][7:0], got);
                    wait_rda();
                    bus_read(spart_pkg::reg_data, got);
                    compare_byte(test_name[i], test_expect[i][7:0], got);
                end
                default: begin
                    send_bad_frame(test_value[i][7:0]);
                    bus_read(spart_pkg::reg_status, got);
                    compare_status(test_name[i], test_expect[i][7:0], got);
                end
            endcase
            if (error_count != errors_before)
                failed_tests++;
            $display("test %0d %s: %s", i, test_name[i],
                     (error_count == errors_before) ? "ok" : "failed");
        end

        $display("%0d tests run, %0d failed, %0d errors", test_name.size(), failed_tests,
                 error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // limit from the table length and the slowest divisor it uses
    initial begin
        longint limit_ns;
        int     max_div;
        wait (table_built);
        max_div = int'(reset_div);
        foreach (test_kind[i])
            if (test_kind[i] == k_divisor && int'(test_value[i]) > max_div)
                max_div = int'(test_value[i]);
        limit_ns = longint'(test_name.size()) * 10 * 16 * (max_div + 1) * clk_period * 2;
        #(limit_ns);
        $display("timeout: tests did not finish within %0d ns", limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* bench/spart_chk.sv */
`timescale 1ns/1ps

module spart_chk (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic txd,
    input logic tx_ready,
    input logic rx_read,
    input logic rda
);

    // ack only answers a pending request
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell before req was released");

    // an idle transmitter holds the line at stop level
    idle_line: assert property (@(posedge clk) disable iff (!rst_n)
        tx_ready |-> txd == uart_frame_pkg::line_idle)
        else $error("txd not idle while transmitter ready");

    rda_cleared: assert property (@(posedge clk) disable iff (!rst_n)
        rx_read |=> !rda)
        else $error("rda still set after a data read");

endmodule

bind spart spart_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .txd      (txd),
    .tx_ready (tx_ready),
    .rx_read  (rx_read),
    .rda      (rda)
);

/* design/spart.sv */
`timescale 1ns/1ps

module spart #(
    parameter logic [15:0] reset_divisor = 16'd26
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 wr,
    input  spart_pkg::reg_addr_t addr,
    input  logic [7:0]           wdata,
    output logic                 ack,
    output logic [7:0]           rdata,
    input  logic                 rxd,
    output logic                 txd
);

    spart_pkg::baud_div_u divisor;

    logic       tick;     // 16x enable
    logic       tx_load;
    logic [7:0] tx_byte;
    logic       tx_ready;
    logic       rx_read;
    logic [7:0] rx_byte;
    logic       rda;
    logic       ferr;

    // host side
    spart_bus_if #(
        .reset_divisor(reset_divisor)
    ) u_bus_if (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .divisor  (divisor),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .rx_read  (rx_read),
        .rx_byte  (rx_byte),
        .rda      (rda),
        .ferr     (ferr)
    );

    spart_baud_gen u_baud_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .divisor (divisor),
        .tick    (tick)
    );

    spart_rx u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .rxd     (rxd),
        .rx_read (rx_read),
        .rx_byte (rx_byte),
        .rda     (rda),
        .ferr    (ferr)
    );

    spart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

endmodule

/* design/spart_bus_if.sv */
`timescale 1ns/1ps

module spart_bus_if #(
    parameter logic [15:0] reset_divisor = 16'd26
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 wr,
    input  spart_pkg::reg_addr_t addr,
    input  logic [7:0]           wdata,
    output logic                 ack,
    output logic [7:0]           rdata,
    output spart_pkg::baud_div_u divisor,
    output logic                 tx_load,
    output logic [7:0]           tx_byte,
    input  logic                 tx_ready,
    output logic                 rx_read,
    input  logic [7:0]           rx_byte,
    input  logic                 rda,
    input  logic                 ferr
);

    typedef enum logic [1:0] {idle, busy, ack_high, wait_low} state_t;
    state_t state;

    logic       data_sel;
    logic       stall;
    logic       do_access; // one-cycle strobe, the edge where ack rises
    logic [7:0] status;

    assign data_sel  = (addr == spart_pkg::reg_data);
    assign stall     = wr && data_sel && !tx_ready; // hold the host off while sending
    assign do_access = (state == busy) && !stall;

    always_comb begin
        status                       = '0;
        status[spart_pkg::stat_tbr]  = tx_ready;
        status[spart_pkg::stat_rda]  = rda;
        status[spart_pkg::stat_ferr] = ferr;
    end

    // four-phase handshake
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            ack     <= 1'b0;
            tx_load <= 1'b0;
            rx_read <= 1'b0;
        end else begin
            tx_load <= 1'b0;
            rx_read <= 1'b0;
            case (state)
                idle:     if (req) state <= busy;
                busy: begin
                    if (do_access) begin
                        state   <= ack_high;
                        ack     <= 1'b1;
                        tx_load <= wr && data_sel;
                        rx_read <= !wr && data_sel;
                    end
                end
                ack_high: state <= wait_low;
                wait_low: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= idle;
                    end
                end
                default:  state <= idle;
            endcase
        end
    end

    // divisor written a byte at a time
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            divisor.value <= reset_divisor;
        end else if (do_access && wr) begin
            case (addr)
                spart_pkg::reg_div_lo: divisor.bytes.lo <= wdata;
                spart_pkg::reg_div_hi: divisor.bytes.hi <= wdata;
                default: ; // status writes are ignored
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_access && wr && data_sel)
            tx_byte <= wdata;
    end

    // read mux, held while ack is high
    always_ff @(posedge clk) begin
        if (do_access && !wr) begin
            case (addr)
                spart_pkg::reg_data:   rdata <= rx_byte;
                spart_pkg::reg_status: rdata <= status;
                spart_pkg::reg_div_lo: rdata <= divisor.bytes.lo;
                default:               rdata <= divisor.bytes.hi;
            endcase
        end
    end

endmodule

/* design/spart_tx.sv */
`timescale 1ns/1ps

module spart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,     // 16x bit rate enable
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    output logic       tx_ready,
    output logic       txd
);

    localparam int frame_bits = uart_frame_pkg::data_bits + 2; // start + data + stop

    logic [frame_bits-1:0] frame;
    logic [3:0]            tick_cnt;
    logic [3:0]            bit_cnt;
    logic                  bit_end;
    logic                  last_bit;

    assign bit_end  = tick && (tick_cnt == 4'(uart_frame_pkg::oversample - 1));
    assign last_bit = (bit_cnt == 4'(frame_bits - 1));
    assign txd      = frame[0];

    // busy from load until the stop bit has run its full length
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            tx_ready <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tx_ready) begin
            if (tx_load) begin
                tx_ready <= 1'b0;
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (tick) begin
            tick_cnt <= tick_cnt + 4'd1;
            if (bit_end) begin
                if (last_bit)
                    tx_ready <= 1'b1;
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // shifter, filled with idle level from the top
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            frame <= '1; // line idles high
        end else if (tx_ready) begin
            if (tx_load)
                frame <= {uart_frame_pkg::line_idle, tx_byte, uart_frame_pkg::line_start};
        end else if (bit_end && !last_bit) begin
            frame <= {uart_frame_pkg::line_idle, frame[frame_bits-1:1]};
        end
    end

endmodule

/* design/spart_rx.sv */
`timescale 1ns/1ps

module spart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,    // 16x bit rate enable
    input  logic       rxd,
    input  logic       rx_read,
    output logic [7:0] rx_byte,
    output logic       rda,     // receive data available
    output logic       ferr
);

    localparam int half_bit = uart_frame_pkg::oversample / 2;

    typedef enum logic [1:0] {idle, start, receive, stop} state_t;
    state_t state, next_state;

    logic       rx_meta, rx_sync; // synchronizer pair
    logic [3:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic       clr_cnt, inc_cnt, shift;
    logic       frame_ok, frame_bad;
    logic       half_done, bit_done;

    assign half_done = tick && (tick_cnt == 4'(half_bit - 1));
    assign bit_done  = tick && (tick_cnt == 4'(uart_frame_pkg::oversample - 1));

    // rxd is asynchronous to clk
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= uart_frame_pkg::line_idle;
            rx_sync <= uart_frame_pkg::line_idle;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        clr_cnt    = 1'b0;
        inc_cnt    = tick;
        shift      = 1'b0;
        frame_ok   = 1'b0;
        frame_bad  = 1'b0;

        case (state)
            idle: begin
                inc_cnt = 1'b0;
                // held off while the last byte is still unread
                if (rx_sync == uart_frame_pkg::line_start && !rda) begin
                    clr_cnt    = 1'b1;
                    next_state = start;
                end
            end

            start: begin
                if (half_done) begin
                    clr_cnt = 1'b1; // from here on count from mid-bit
                    if (rx_sync == uart_frame_pkg::line_start)
                        next_state = receive;
                    else
                        next_state = idle; // glitch, not a start bit
                end
            end

            receive: begin
                if (bit_done) begin
                    shift = 1'b1;
                    if (bit_cnt == 4'(uart_frame_pkg::data_bits - 1))
                        next_state = stop;
                end
            end

            stop: begin
                if (bit_done) begin
                    if (rx_sync == uart_frame_pkg::line_idle)
                        frame_ok = 1'b1;
                    else
                        frame_bad = 1'b1;
                    next_state = idle;
                end
            end

            default: next_state = idle;
        endcase
    end

    // tick_cnt wraps 15 -> 0 at each bit centre
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (clr_cnt) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (inc_cnt)
                tick_cnt <= tick_cnt + 4'd1;
            if (shift)
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (shift)
            rx_byte <= {rx_sync, rx_byte[7:1]}; // lsb arrives first
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rda  <= 1'b0;
            ferr <= 1'b0;
        end else begin
            if (frame_ok)
                rda <= 1'b1;
            else if (rx_read)
                rda <= 1'b0;

            if (frame_ok)
                ferr <= 1'b0;
            else if (frame_bad)
                ferr <= 1'b1; // rda stays clear, byte is dropped
        end
    end

endmodule

/* design/spart_baud_gen.sv */
`timescale 1ns/1ps

module spart_baud_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  spart_pkg::baud_div_u divisor,
    output logic                 tick
);

    logic [15:0] count;

    // down-counter, one tick per divisor+1 clocks
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == 16'd0) begin
            count <= divisor.value; // a new divisor is picked up here
            tick  <= 1'b1;
        end else begin
            count <= count - 16'd1;
            tick  <= 1'b0;
        end
    end

endmodule

/* design/uart_frame_pkg.sv */
package uart_frame_pkg;

    // enable pulses per serial bit
    localparam int oversample = 16;

    // payload bits per frame, sent lsb first
    localparam int data_bits = 8;

    // line levels
    localparam logic line_idle  = 1'b1; // idle and stop level
    localparam logic line_start = 1'b0;

endpackage

/* design/spart_pkg.sv */
package spart_pkg;

    // host register map
    typedef enum logic [1:0] {
        reg_data   = 2'd0, // write sends, read takes the received byte
        reg_status = 2'd1,
        reg_div_lo = 2'd2,
        reg_div_hi = 2'd3
    } reg_addr_t;

    // bit positions in the status byte, the rest read as zero
    localparam int stat_tbr  = 0; // transmit buffer ready
    localparam int stat_rda  = 1; // receive data available
    localparam int stat_ferr = 2; // framing error on last frame

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } div_bytes_t;

    // one divisor word, counted as a number by the baud generator
    // and written byte by byte from the host side
    typedef union packed {
        logic [15:0] value;
        div_bytes_t  bytes;
    } baud_div_u;

endpackage
